// File: common/ooo_pkg.sv
/*
 * Shared widths, ALU opcodes and the packed structs passed between
 * the reservation stations, issue logic, ALU and CDB
 */
package ooo_pkg;

    localparam int XLEN     = 32;
    localparam int TAG_W    = 4;
    localparam int RS_DEPTH = 4;
    localparam int RS_IDX_W = $clog2(RS_DEPTH);
    localparam int SHAMT_W  = 5;

    // Tag 0 marks an operand that already holds its value
    localparam logic [TAG_W-1:0] NO_TAG = '0;

    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        SLL = 3'd5,
        SRL = 3'd6,
        SLT = 3'd7
    } alu_op_e;

    // Renamed instruction as it arrives at dispatch
    typedef struct packed {
        alu_op_e           op;
        logic [TAG_W-1:0]  rob_tag;
        logic [TAG_W-1:0]  qj;
        logic [TAG_W-1:0]  qk;
        logic [XLEN-1:0]   vj;
        logic [XLEN-1:0]   vk;
    } rs_dispatch_t;

    // Contents of one station
    typedef struct packed {
        logic          busy;
        rs_dispatch_t  inst;
    } rs_slot_t;

    // Operation handed from issue to the ALU
    typedef struct packed {
        alu_op_e           op;
        logic [TAG_W-1:0]  rob_tag;
        logic [XLEN-1:0]   a;
        logic [XLEN-1:0]   b;
    } alu_req_t;

    // Result from a functional unit, qualified by a separate valid
    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        logic [XLEN-1:0]   result;
    } fu_result_t;

    // Common data bus broadcast
    typedef struct packed {
        logic              valid;
        logic [TAG_W-1:0]  tag;
        logic [XLEN-1:0]   result;
    } cdb_packet_t;

endpackage

// File: hdl/alu_unit.sv
/*
 * Integer ALU with a one-deep registered output stage
 * that holds its result under back-pressure
 */
`timescale 1ns/1ps

module alu_unit (
    input  logic                clk,
    input  logic                reset,
    input  logic                flush,
    input  ooo_pkg::alu_req_t   alu_req,
    input  logic                req_valid,
    output logic                req_ready,
    output ooo_pkg::fu_result_t alu_result,
    output logic                alu_valid,
    input  logic                alu_ready
);

    logic [ooo_pkg::XLEN-1:0] result;
    logic                     signed_lt;
    logic                     accept;

    assign signed_lt = $signed(alu_req.a) < $signed(alu_req.b);

    always_comb begin
        case (alu_req.op)
            ooo_pkg::ADD: result = alu_req.a + alu_req.b;
            ooo_pkg::SUB: result = alu_req.a - alu_req.b;
            ooo_pkg::AND: result = alu_req.a & alu_req.b;
            ooo_pkg::OR:  result = alu_req.a | alu_req.b;
            ooo_pkg::XOR: result = alu_req.a ^ alu_req.b;
            // Shift amount is the low bits of b
            ooo_pkg::SLL: result = alu_req.a << alu_req.b[ooo_pkg::SHAMT_W-1:0];
            ooo_pkg::SRL: result = alu_req.a >> alu_req.b[ooo_pkg::SHAMT_W-1:0];
            ooo_pkg::SLT: result = {{(ooo_pkg::XLEN - 1){1'b0}}, signed_lt};
            default:      result = '0;
        endcase
    end

    // Take a new request when empty or when the held result drains
    assign req_ready = ~alu_valid | alu_ready;
    assign accept    = req_valid & req_ready;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            alu_valid <= 1'b0;
        end else if (accept) begin
            alu_valid <= 1'b1;
        end else if (alu_ready) begin
            alu_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            alu_result.tag    <= alu_req.rob_tag;
            alu_result.result <= result;
        end
    end

endmodule

// File: hdl/cdb_arbiter.sv
/*
 * Merges external and ALU results onto the common data bus,
 * external results first
 */
`timescale 1ns/1ps

module cdb_arbiter (
    input  ooo_pkg::fu_result_t  ext_result,
    input  logic                 ext_valid,
    output logic                 ext_ready,
    input  ooo_pkg::fu_result_t  alu_result,
    input  logic                 alu_valid,
    output logic                 alu_ready,
    output ooo_pkg::cdb_packet_t cdb
);

    // External producers are never stalled
    assign ext_ready = 1'b1;

    // ALU waits whenever an external result holds the bus
    assign alu_ready = ~ext_valid;

    always_comb begin
        cdb.valid = ext_valid | alu_valid;
        if (ext_valid) begin
            cdb.tag    = ext_result.tag;
            cdb.result = ext_result.result;
        end else begin
            cdb.tag    = alu_result.tag;
            cdb.result = alu_result.result;
        end
    end

endmodule

// File: hdl/issue_select.sv
/*
 * Picks the lowest-index station with both operands ready
 * and hands it to the ALU
 */
`timescale 1ns/1ps

module issue_select (
    input  ooo_pkg::rs_slot_t [ooo_pkg::RS_DEPTH-1:0]    slots,
    output ooo_pkg::alu_req_t                            alu_req,
    output logic                                         req_valid,
    input  logic                                         req_ready,
    output logic [ooo_pkg::RS_DEPTH-1:0]                 rs_release
);

    logic [ooo_pkg::RS_DEPTH-1:0] ready;
    logic [ooo_pkg::RS_IDX_W-1:0] pick_idx;

    always_comb begin
        pick_idx = '0;
        // Scan downward so the lowest ready index is the last one kept
        for (int i = ooo_pkg::RS_DEPTH - 1; i >= 0; i--) begin
            ready[i] = slots[i].busy
                    && (slots[i].inst.qj == ooo_pkg::NO_TAG)
                    && (slots[i].inst.qk == ooo_pkg::NO_TAG);
            if (ready[i]) begin
                pick_idx = ooo_pkg::RS_IDX_W'(i);
            end
        end
    end

    assign req_valid       = |ready;
    assign alu_req.op      = slots[pick_idx].inst.op;
    assign alu_req.rob_tag = slots[pick_idx].inst.rob_tag;
    assign alu_req.a       = slots[pick_idx].inst.vj;
    assign alu_req.b       = slots[pick_idx].inst.vk;

    // Free the station only when the ALU takes it
    assign rs_release = (req_valid && req_ready)
                      ? ({{(ooo_pkg::RS_DEPTH - 1){1'b0}}, 1'b1} << pick_idx)
                      : '0;

endmodule

// File: hdl/ooo_exec_top.sv
/*
 * Issue-to-execute slice: reservation stations, issue select,
 * ALU and CDB arbiter
 */
`timescale 1ns/1ps

module ooo_exec_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,
    input  ooo_pkg::rs_dispatch_t dispatch,
    input  logic                  dispatch_valid,
    output logic                  dispatch_ready,
    input  ooo_pkg::fu_result_t   ext_result,
    input  logic                  ext_valid,
    output logic                  ext_ready,
    output ooo_pkg::cdb_packet_t  cdb
);

    ooo_pkg::rs_slot_t [ooo_pkg::RS_DEPTH-1:0] slots;
    logic [ooo_pkg::RS_DEPTH-1:0]              rs_release;
    ooo_pkg::alu_req_t                         alu_req;
    logic                                      req_valid;
    logic                                      req_ready;
    ooo_pkg::fu_result_t                       alu_result;
    logic                                      alu_valid;
    logic                                      alu_ready;

    rs_bank u_rs_bank (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .dispatch       (dispatch),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .cdb            (cdb),
        .rs_release     (rs_release),
        .slots          (slots)
    );

    issue_select u_issue_select (
        .slots      (slots),
        .alu_req    (alu_req),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .rs_release (rs_release)
    );

    alu_unit u_alu_unit (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .alu_req    (alu_req),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .alu_result (alu_result),
        .alu_valid  (alu_valid),
        .alu_ready  (alu_ready)
    );

    cdb_arbiter u_cdb_arbiter (
        .ext_result (ext_result),
        .ext_valid  (ext_valid),
        .ext_ready  (ext_ready),
        .alu_result (alu_result),
        .alu_valid  (alu_valid),
        .alu_ready  (alu_ready),
        .cdb        (cdb)
    );

endmodule

// File: rs/rs_bank.sv
/*
 * Bank of reservation stations with lowest-free allocation
 * and the dispatch handshake
 */
`timescale 1ns/1ps

module rs_bank (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic                                         flush,
    input  ooo_pkg::rs_dispatch_t                        dispatch,
    input  logic                                         dispatch_valid,
    output logic                                         dispatch_ready,
    input  ooo_pkg::cdb_packet_t                         cdb,
    input  logic [ooo_pkg::RS_DEPTH-1:0]                 rs_release,
    output ooo_pkg::rs_slot_t [ooo_pkg::RS_DEPTH-1:0]    slots
);

    logic [ooo_pkg::RS_DEPTH-1:0] free;
    logic [ooo_pkg::RS_DEPTH-1:0] alloc;
    logic [ooo_pkg::RS_DEPTH-1:0] write;

    // Priority encoder, lowest free index wins
    always_comb begin
        alloc = '0;
        for (int i = 0; i < ooo_pkg::RS_DEPTH; i++) begin
            if (free[i] && (alloc == '0)) begin
                alloc[i] = 1'b1;
            end
        end
    end

    assign dispatch_ready = (|free) && !flush;
    assign write          = alloc & {ooo_pkg::RS_DEPTH{dispatch_valid && dispatch_ready}};

    for (genvar i = 0; i < ooo_pkg::RS_DEPTH; i++) begin : g_entry
        rs_entry u_entry (
            .clk        (clk),
            .reset      (reset),
            .flush      (flush),
            .rs_release (rs_release[i]),
            .write      (write[i]),
            .wdata      (dispatch),
            .cdb        (cdb),
            .slot       (slots[i])
        );

        assign free[i] = ~slots[i].busy;
    end

endmodule

// File: rs/rs_entry.sv
/*
 * Single reservation station holding one instruction,
 * with CDB operand capture and a bypass on the write cycle
 */
`timescale 1ns/1ps

module rs_entry (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,
    input  logic                  rs_release,
    input  logic                  write,
    input  ooo_pkg::rs_dispatch_t wdata,
    input  ooo_pkg::cdb_packet_t  cdb,
    output ooo_pkg::rs_slot_t     slot
);

    logic                          busy_q;
    ooo_pkg::rs_dispatch_t         inst_q;

    // Operand source is the incoming word on a write, else the held one
    logic [ooo_pkg::TAG_W-1:0]     src_qj;
    logic [ooo_pkg::TAG_W-1:0]     src_qk;
    logic [ooo_pkg::XLEN-1:0]      src_vj;
    logic [ooo_pkg::XLEN-1:0]      src_vk;
    logic                          hit_j;
    logic                          hit_k;

    always_comb begin
        src_qj = write ? wdata.qj : inst_q.qj;
        src_qk = write ? wdata.qk : inst_q.qk;
        src_vj = write ? wdata.vj : inst_q.vj;
        src_vk = write ? wdata.vk : inst_q.vk;
        // Only a real waiting tag can match the bus
        hit_j  = cdb.valid && (src_qj != ooo_pkg::NO_TAG) && (src_qj == cdb.tag);
        hit_k  = cdb.valid && (src_qk != ooo_pkg::NO_TAG) && (src_qk == cdb.tag);
    end

    always_ff @(posedge clk) begin
        if (reset || flush || rs_release) begin
            busy_q <= 1'b0;
        end else if (write) begin
            busy_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (write) begin
            inst_q.op      <= wdata.op;
            inst_q.rob_tag <= wdata.rob_tag;
        end
        if (write || hit_j) begin
            inst_q.qj <= hit_j ? ooo_pkg::NO_TAG : src_qj;
            inst_q.vj <= hit_j ? cdb.result : src_vj;
        end
        if (write || hit_k) begin
            inst_q.qk <= hit_k ? ooo_pkg::NO_TAG : src_qk;
            inst_q.vk <= hit_k ? cdb.result : src_vk;
        end
    end

    assign slot.busy = busy_q;
    assign slot.inst = inst_q;

endmodule

// File: tb/ooo_exec_properties.sv
/*
 * Concurrent assertions on the CDB, station release and dispatch
 * handshake, bound to the top level
 */
`timescale 1ns/1ps

module ooo_exec_properties (
    input logic                                      clk,
    input logic                                      reset,
    input logic                                      flush,
    input logic                                      dispatch_valid,
    input logic                                      dispatch_ready,
    input ooo_pkg::cdb_packet_t                      cdb,
    input logic [ooo_pkg::RS_DEPTH-1:0]              rs_release
);

    int occupancy;

    // Stations in use, counted from accepted dispatches and releases
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            occupancy <= 0;
        end else begin
            occupancy <= occupancy + int'(dispatch_valid && dispatch_ready)
                       - int'(|rs_release);
        end
    end

    // Tag 0 never goes out on the bus
    cdb_tag_nonzero: assert property (@(posedge clk) disable iff (reset)
        cdb.valid |-> cdb.tag != ooo_pkg::NO_TAG)
        else $error("CDB broadcast with tag zero");

    release_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(rs_release))
        else $error("more than one station released in a cycle");

    full_blocks_dispatch: assert property (@(posedge clk) disable iff (reset)
        occupancy == ooo_pkg::RS_DEPTH |-> !dispatch_ready)
        else $error("dispatch_ready high with every station busy");

    ready_after_reset: assert property (@(posedge clk)
        $past(reset) && !reset && !flush |-> dispatch_ready)
        else $error("dispatch_ready low in the cycle after reset");

endmodule

bind ooo_exec_top ooo_exec_properties u_properties (
    .clk            (clk),
    .reset          (reset),
    .flush          (flush),
    .dispatch_valid (dispatch_valid),
    .dispatch_ready (dispatch_ready),
    .cdb            (cdb),
    .rs_release     (rs_release)
);

// File: tb/ooo_exec_tb.sv
/*
 * Testbench for the issue-to-execute slice: clock, reset, dispatch and
 * external broadcast stimulus, reference ALU model, CDB scoreboard, timeout
 */
`timescale 1ns/1ps

module ooo_exec_tb;

    localparam int NTAGS      = 1 << ooo_pkg::TAG_W;
    localparam int N_INSTR    = 48;
    localparam int MAX_CYCLES = 40 * N_INSTR + 200;

    logic                  clk;
    logic                  reset;
    logic                  flush;
    ooo_pkg::rs_dispatch_t dispatch;
    logic                  dispatch_valid;
    logic                  dispatch_ready;
    ooo_pkg::fu_result_t   ext_result;
    logic                  ext_valid;
    logic                  ext_ready;
    ooo_pkg::cdb_packet_t  cdb;

    // Scoreboard, indexed by ROB tag
    logic                  exp_valid [NTAGS];
    logic [31:0]           exp_val   [NTAGS];
    logic                  known     [NTAGS];
    logic [31:0]           known_val [NTAGS];
    logic                  p_active  [NTAGS];
    ooo_pkg::rs_dispatch_t p_inst    [NTAGS];
    int                    outstanding = 0;
    int                    cycles = 0;
    logic [31:0]           seed = 32'h7524_12c3;

    ooo_exec_top DUT (
        .clk            (clk),
        .reset          (reset),
        .flush          (flush),
        .dispatch       (dispatch),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .ext_result     (ext_result),
        .ext_valid      (ext_valid),
        .ext_ready      (ext_ready),
        .cdb            (cdb)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [31:0] alu_ref(ooo_pkg::alu_op_e op, logic [31:0] a,
                                            logic [31:0] b);
        case (op)
            ooo_pkg::ADD: return a + b;
            ooo_pkg::SUB: return a - b;
            ooo_pkg::AND: return a & b;
            ooo_pkg::OR:  return a | b;
            ooo_pkg::XOR: return a ^ b;
            ooo_pkg::SLL: return a << b[4:0];
            ooo_pkg::SRL: return a >> b[4:0];
            ooo_pkg::SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:      return 32'd0;
        endcase
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "stopping on first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            fail_run($sformatf("** Error at %0t: %s, got %h, expected %h",
                               $time, what, got, expected));
        end
    endtask

    // Expected result known once both operands are values
    function automatic void try_resolve(int i);
        if (p_active[i] && p_inst[i].qj == ooo_pkg::NO_TAG
                && p_inst[i].qk == ooo_pkg::NO_TAG) begin
            exp_val[i]   = alu_ref(p_inst[i].op, p_inst[i].vj, p_inst[i].vk);
            exp_valid[i] = 1'b1;
            p_active[i]  = 1'b0;
        end
    endfunction

    function automatic void wake_dependents(logic [3:0] t, logic [31:0] v);
        known[t]     = 1'b1;
        known_val[t] = v;
        for (int i = 0; i < NTAGS; i++) begin
            if (p_active[i] && p_inst[i].qj == t) begin
                p_inst[i].qj = ooo_pkg::NO_TAG;
                p_inst[i].vj = v;
            end
            if (p_active[i] && p_inst[i].qk == t) begin
                p_inst[i].qk = ooo_pkg::NO_TAG;
                p_inst[i].vk = v;
            end
            try_resolve(i);
        end
    endfunction

    // Rename stand-in: operands of retired producers become values
    function automatic void register_inst(ooo_pkg::rs_dispatch_t w);
        if (w.qj != ooo_pkg::NO_TAG && known[w.qj]) begin
            w.vj = known_val[w.qj];
            w.qj = ooo_pkg::NO_TAG;
        end
        if (w.qk != ooo_pkg::NO_TAG && known[w.qk]) begin
            w.vk = known_val[w.qk];
            w.qk = ooo_pkg::NO_TAG;
        end
        known[w.rob_tag]    = 1'b0;
        p_inst[w.rob_tag]   = w;
        p_active[w.rob_tag] = 1'b1;
        outstanding++;
        try_resolve(w.rob_tag);
    endfunction

    function automatic ooo_pkg::rs_dispatch_t make_word(logic [3:0] tag, logic [3:0] qj,
                                                        logic [3:0] qk);
        ooo_pkg::rs_dispatch_t w;
        logic [31:0]           r;
        r         = next_rand();
        w.op      = ooo_pkg::alu_op_e'(r[31:29]);
        w.rob_tag = tag;
        w.qj      = qj;
        w.qk      = qk;
        w.vj      = next_rand();
        w.vk      = next_rand();
        return w;
    endfunction

    // Word is re-driven while stalled so late wakeups reach the DUT
    task automatic dispatch_inst(input ooo_pkg::rs_dispatch_t w);
        register_inst(w);
        @(negedge clk);
        dispatch       = p_inst[w.rob_tag];
        dispatch_valid = 1'b1;
        @(posedge clk);
        while (!dispatch_ready) begin
            @(negedge clk);
            dispatch = p_inst[w.rob_tag];
            @(posedge clk);
        end
        @(negedge clk);
        dispatch_valid = 1'b0;
    endtask

    task automatic drive_ext(input logic [3:0] tag, input logic [31:0] val);
        exp_valid[tag]    = 1'b1;
        exp_val[tag]      = val;
        known[tag]        = 1'b0;
        outstanding++;
        ext_result.tag    = tag;
        ext_result.result = val;
        ext_valid         = 1'b1;
    endtask

    task automatic send_ext(input logic [3:0] tag, input logic [31:0] val);
        @(negedge clk);
        drive_ext(tag, val);
        @(posedge clk);
        while (!ext_ready) @(posedge clk);
        @(negedge clk);
        ext_valid = 1'b0;
    endtask

    // Back-to-back external packets on tags 13 to 15
    task automatic ext_burst(input int n);
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            drive_ext(4'(13 + i % 3), next_rand());
        end
        @(negedge clk);
        ext_valid = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic wait_idle();
        @(negedge clk);
        while (outstanding != 0) @(negedge clk);
        for (int i = 0; i < NTAGS; i++) begin
            known[i] = 1'b0;
        end
    endtask

    task automatic flush_all();
        @(negedge clk);
        flush = 1'b1;
        for (int i = 0; i < NTAGS; i++) begin
            if (p_active[i]) begin
                p_active[i] = 1'b0;
                outstanding--;
            end
        end
        @(negedge clk);
        flush = 1'b0;
        @(posedge clk);
        check_value("dispatch_ready after flush", dispatch_ready, 1'b1);
    endtask

    // Scoreboard compare on every CDB broadcast
    always @(posedge clk) begin : compare_cdb
        logic [3:0] t;
        // External producers are never held off
        if (!reset) begin
            check_value("ext_ready", ext_ready, 1'b1);
        end
        if (!reset && cdb.valid === 1'b1) begin
            t = cdb.tag;
            check_value($sformatf("tag %0d owed on CDB", t), exp_valid[t], 1'b1);
            check_value($sformatf("CDB result for tag %0d", t), cdb.result, exp_val[t]);
            exp_valid[t] = 1'b0;
            outstanding--;
            wake_dependents(t, cdb.result);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            fail_run($sformatf("Timeout: run did not finish within %0d cycles", MAX_CYCLES));
        end
    end

    initial begin
        reset          = 1'b1;
        flush          = 1'b0;
        dispatch       = '0;
        dispatch_valid = 1'b0;
        ext_result     = '0;
        ext_valid      = 1'b0;
        for (int i = 0; i < NTAGS; i++) begin
            exp_valid[i] = 1'b0;
            known[i]     = 1'b0;
            p_active[i]  = 1'b0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Independent instructions
        for (int i = 1; i <= 12; i++) begin
            dispatch_inst(make_word(4'(i), ooo_pkg::NO_TAG, ooo_pkg::NO_TAG));
        end
        wait_idle();

        // Dependent chains on ALU producers
        dispatch_inst(make_word(4'd1, ooo_pkg::NO_TAG, ooo_pkg::NO_TAG));
        dispatch_inst(make_word(4'd2, 4'd1, ooo_pkg::NO_TAG));
        dispatch_inst(make_word(4'd3, ooo_pkg::NO_TAG, 4'd2));
        dispatch_inst(make_word(4'd4, 4'd1, 4'd3));
        dispatch_inst(make_word(4'd5, ooo_pkg::NO_TAG, ooo_pkg::NO_TAG));
        dispatch_inst(make_word(4'd6, 4'd5, 4'd5));
        dispatch_inst(make_word(4'd7, 4'd6, 4'd4));
        dispatch_inst(make_word(4'd8, 4'd7, ooo_pkg::NO_TAG));
        wait_idle();

        // Producer broadcast in the same cycle as dispatch
        fork
            send_ext(4'd13, next_rand());
            dispatch_inst(make_word(4'd9, 4'd13, ooo_pkg::NO_TAG));
        join
        wait_idle();
        fork
            send_ext(4'd14, next_rand());
            dispatch_inst(make_word(4'd10, ooo_pkg::NO_TAG, 4'd14));
        join
        wait_idle();

        // Wakeups from external producers
        dispatch_inst(make_word(4'd1, 4'd13, ooo_pkg::NO_TAG));
        dispatch_inst(make_word(4'd2, ooo_pkg::NO_TAG, 4'd14));
        dispatch_inst(make_word(4'd3, 4'd13, 4'd14));
        dispatch_inst(make_word(4'd4, 4'd2, 4'd13));
        idle_cycles(4);
        send_ext(4'd13, next_rand());
        idle_cycles(2);
        send_ext(4'd14, next_rand());
        wait_idle();

        // All stations stalled on one external tag
        for (int i = 1; i <= 4; i++) begin
            dispatch_inst(make_word(4'(i), 4'd15, ooo_pkg::NO_TAG));
        end
        repeat (6) begin
            @(posedge clk);
            check_value("dispatch_ready with all stations busy", dispatch_ready, 1'b0);
        end
        send_ext(4'd15, next_rand());
        wait_idle();

        // ALU results held back under a long external burst
        fork
            for (int i = 1; i <= 8; i++) begin
                dispatch_inst(make_word(4'(i), ooo_pkg::NO_TAG, ooo_pkg::NO_TAG));
            end
            begin
                idle_cycles(3);
                ext_burst(30);
            end
        join
        wait_idle();

        // Flush of waiting instructions, then normal operation
        dispatch_inst(make_word(4'd9, 4'd14, ooo_pkg::NO_TAG));
        dispatch_inst(make_word(4'd10, ooo_pkg::NO_TAG, 4'd14));
        dispatch_inst(make_word(4'd11, 4'd14, 4'd14));
        idle_cycles(3);
        flush_all();
        send_ext(4'd14, next_rand());
        for (int i = 1; i <= 6; i++) begin
            dispatch_inst(make_word(4'(i), ooo_pkg::NO_TAG, ooo_pkg::NO_TAG));
        end
        dispatch_inst(make_word(4'd7, 4'd1, 4'd6));
        wait_idle();
        idle_cycles(10);

        $display("Simulation passed");
        $finish;
    end

endmodule

// File: verilog.f
common/ooo_pkg.sv
rs/rs_entry.sv
rs/rs_bank.sv
hdl/issue_select.sv
hdl/alu_unit.sv
hdl/cdb_arbiter.sv
hdl/ooo_exec_top.sv
tb/ooo_exec_properties.sv
tb/ooo_exec_tb.sv
